// File: rtl/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath word, also the pc width
`define XLEN   32

// register file address
`define REG_AW 5

`endif

// File: rtl/exe_pkg.sv
package exe_pkg;

    // funct3 order, opt bit picks sub / sra
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SLL  = 3'd1,
        ALU_SLT  = 3'd2,
        ALU_SLTU = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SR   = 3'd5,
        ALU_OR   = 3'd6,
        ALU_AND  = 3'd7
    } alu_fn_e;

    typedef enum logic [3:0] {
        BJ_NONE = 4'd0,
        BJ_BEQ  = 4'd1,
        BJ_BNE  = 4'd2,
        BJ_BLT  = 4'd3,
        BJ_BGE  = 4'd4,
        BJ_BLTU = 4'd5,
        BJ_BGEU = 4'd6,
        BJ_JAL  = 4'd7,
        BJ_JALR = 4'd8   // target base is rs1
    } bj_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    typedef enum logic [1:0] {
        MW_BYTE = 2'd0,
        MW_HALF = 2'd1,
        MW_WORD = 2'd2
    } mem_width_e;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module alu
    import exe_pkg::*;
(
    input  logic [`XLEN-1:0] in_a,
    input  logic [`XLEN-1:0] in_b,
    input  alu_fn_e          fn,
    input  logic             opt,
    output logic [`XLEN-1:0] result
);

    logic [4:0]       shamt;
    logic             lt_signed;
    logic             lt_unsigned;
    logic [`XLEN-1:0] add_sub;

    assign shamt       = in_b[4:0];            // only low bits count
    assign lt_signed   = $signed(in_a) < $signed(in_b);
    assign lt_unsigned = in_a < in_b;
    assign add_sub     = opt ? (in_a - in_b) : (in_a + in_b);

    always_comb begin
        case (fn)
            ALU_ADD: begin
                result = add_sub;
            end
            ALU_SLL: begin
                result = in_a << shamt;
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = in_a ^ in_b;
            end
            ALU_SR: begin
                if (opt) begin
                    result = $unsigned($signed(in_a) >>> shamt);   // sra
                end else begin
                    result = in_a >> shamt;
                end
            end
            ALU_OR: begin
                result = in_a | in_b;
            end
            ALU_AND: begin
                result = in_a & in_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rtl/branch_ctrl.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module branch_ctrl
    import exe_pkg::*;
(
    input  bj_e              bj_inst,
    input  logic [`XLEN-1:0] in_a,
    input  logic [`XLEN-1:0] in_b,
    output logic             branch
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = in_a == in_b;
    assign lt  = $signed(in_a) < $signed(in_b);
    assign ltu = in_a < in_b;

    always_comb begin
        case (bj_inst)
            BJ_BEQ:  branch = eq;
            BJ_BNE:  branch = !eq;
            BJ_BLT:  branch = lt;
            BJ_BGE:  branch = !lt;
            BJ_BLTU: branch = ltu;
            BJ_BGEU: branch = !ltu;
            BJ_JAL:  branch = 1'b1;    // jumps always taken
            BJ_JALR: branch = 1'b1;
            default: branch = 1'b0;    // none and unused codes
        endcase
    end

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module forwarding_unit
    import exe_pkg::*;
(
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    input  logic [`REG_AW-1:0] wrt_dst_mem,
    input  logic [`REG_AW-1:0] wrt_dst_wb,
    input  logic               reg_wrt_en_mem,
    input  logic               reg_wrt_en_wb,
    output fwd_sel_e           fwd_a,
    output fwd_sel_e           fwd_b
);

    logic a_mem_hit;
    logic a_wb_hit;
    logic b_mem_hit;
    logic b_wb_hit;

    // x0 never forwarded
    assign a_mem_hit = reg_wrt_en_mem && (rs1 != '0) && (rs1 == wrt_dst_mem);
    assign a_wb_hit  = reg_wrt_en_wb  && (rs1 != '0) && (rs1 == wrt_dst_wb);
    assign b_mem_hit = reg_wrt_en_mem && (rs2 != '0) && (rs2 == wrt_dst_mem);
    assign b_wb_hit  = reg_wrt_en_wb  && (rs2 != '0) && (rs2 == wrt_dst_wb);

    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (a_mem_hit) begin
            fwd_a = FWD_MEM;                   // younger result wins
        end else if (a_wb_hit) begin
            fwd_a = FWD_WB;
        end
        if (b_mem_hit) begin
            fwd_b = FWD_MEM;
        end else if (b_wb_hit) begin
            fwd_b = FWD_WB;
        end
    end

endmodule

// File: rtl/execute.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module execute
    import exe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`XLEN-1:0]   next_pc_exe,
    input  logic [`XLEN-1:0]   reg1,
    input  logic [`XLEN-1:0]   reg2,
    input  logic [`XLEN-1:0]   imm,
    input  bj_e                bj_inst_exe,
    input  alu_fn_e            alu_fn_exe,
    input  logic               alu_opt_exe,
    input  logic               data_sel_exe,
    input  wb_sel_e            wb_sel_exe,
    input  mem_width_e         read_width_exe,
    input  logic [`REG_AW-1:0] wrt_dst_exe,
    input  logic               mem_wrt_en_exe,
    input  logic               reg_wrt_en_exe,
    input  logic               read_unsigned_exe,
    input  logic               rd_en_exe,
    input  fwd_sel_e           fwd_a,
    input  fwd_sel_e           fwd_b,
    input  logic [`XLEN-1:0]   wbdata_wb,
    input  logic               stall_mem,
    output logic [`XLEN-1:0]   next_pc_mem,
    output logic [`XLEN-1:0]   write_data_mem,
    output logic [`XLEN-1:0]   alu_result_mem,
    output logic [`XLEN-1:0]   branch_pc,
    output logic               branch,
    output wb_sel_e            wb_sel_mem,
    output mem_width_e         read_width_mem,
    output logic [`REG_AW-1:0] wrt_dst_mem,
    output logic               mem_wrt_en_mem,
    output logic               reg_wrt_en_mem,
    output logic               read_unsigned_mem,
    output logic               rd_en_mem
);

    logic [`XLEN-1:0] fwd_reg1;
    logic [`XLEN-1:0] fwd_reg2;
    logic [`XLEN-1:0] alu_in_b;
    logic [`XLEN-1:0] branch_base;
    logic [`XLEN-1:0] alu_result_exe;

    always_comb begin
        case (fwd_a)
            FWD_MEM: fwd_reg1 = alu_result_mem;
            FWD_WB:  fwd_reg1 = wbdata_wb;
            default: fwd_reg1 = reg1;
        endcase
        case (fwd_b)
            FWD_MEM: fwd_reg2 = alu_result_mem;
            FWD_WB:  fwd_reg2 = wbdata_wb;
            default: fwd_reg2 = reg2;
        endcase
    end

    assign alu_in_b    = data_sel_exe ? imm : fwd_reg2;
    assign branch_base = (bj_inst_exe == BJ_JALR) ? fwd_reg1 : next_pc_exe;
    assign branch_pc   = branch_base + imm;         // pc-relative or rs1-relative

    alu i_alu (
        .in_a   (fwd_reg1),
        .in_b   (alu_in_b),
        .fn     (alu_fn_exe),
        .opt    (alu_opt_exe),
        .result (alu_result_exe)
    );

    branch_ctrl i_branch_ctrl (
        .bj_inst (bj_inst_exe),
        .in_a    (fwd_reg1),
        .in_b    (fwd_reg2),
        .branch  (branch)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc_mem       <= '0;
            write_data_mem    <= '0;
            alu_result_mem    <= '0;
            wb_sel_mem        <= WB_ALU;
            read_width_mem    <= MW_BYTE;
            wrt_dst_mem       <= '0;
            mem_wrt_en_mem    <= 1'b0;
            reg_wrt_en_mem    <= 1'b0;
            read_unsigned_mem <= 1'b0;
            rd_en_mem         <= 1'b0;
        end else if (!stall_mem) begin                 // hold while mem stalls
            next_pc_mem       <= next_pc_exe;
            write_data_mem    <= fwd_reg2;             // store data
            alu_result_mem    <= alu_result_exe;
            wb_sel_mem        <= wb_sel_exe;
            read_width_mem    <= read_width_exe;
            wrt_dst_mem       <= wrt_dst_exe;
            mem_wrt_en_mem    <= mem_wrt_en_exe;
            reg_wrt_en_mem    <= reg_wrt_en_exe;
            read_unsigned_mem <= read_unsigned_exe;
            rd_en_mem         <= rd_en_exe;
        end
    end

endmodule

// File: rtl/exe_top.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_top
    import exe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`XLEN-1:0]   next_pc_exe,
    input  logic [`XLEN-1:0]   reg1,
    input  logic [`XLEN-1:0]   reg2,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`REG_AW-1:0] rs1_exe,
    input  logic [`REG_AW-1:0] rs2_exe,
    input  bj_e                bj_inst_exe,
    input  alu_fn_e            alu_fn_exe,
    input  logic               alu_opt_exe,
    input  logic               data_sel_exe,
    input  wb_sel_e            wb_sel_exe,
    input  mem_width_e         read_width_exe,
    input  logic [`REG_AW-1:0] wrt_dst_exe,
    input  logic               mem_wrt_en_exe,
    input  logic               reg_wrt_en_exe,
    input  logic               read_unsigned_exe,
    input  logic               rd_en_exe,
    input  logic [`REG_AW-1:0] wrt_dst_wb,
    input  logic               reg_wrt_en_wb,
    input  logic [`XLEN-1:0]   wbdata_wb,
    input  logic               stall_mem,
    output logic [`XLEN-1:0]   next_pc_mem,
    output logic [`XLEN-1:0]   write_data_mem,
    output logic [`XLEN-1:0]   alu_result_mem,
    output logic [`XLEN-1:0]   branch_pc,
    output logic               branch,
    output wb_sel_e            wb_sel_mem,
    output mem_width_e         read_width_mem,
    output logic [`REG_AW-1:0] wrt_dst_mem,
    output logic               mem_wrt_en_mem,
    output logic               reg_wrt_en_mem,
    output logic               read_unsigned_mem,
    output logic               rd_en_mem
);

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    // mem-stage dst and enable loop back from the ex/mem register
    forwarding_unit i_forwarding_unit (
        .rs1            (rs1_exe),
        .rs2            (rs2_exe),
        .wrt_dst_mem    (wrt_dst_mem),
        .wrt_dst_wb     (wrt_dst_wb),
        .reg_wrt_en_mem (reg_wrt_en_mem),
        .reg_wrt_en_wb  (reg_wrt_en_wb),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b)
    );

    execute i_execute (
        .clk (clk), .rst_n (rst_n),
        .next_pc_exe (next_pc_exe), .reg1 (reg1), .reg2 (reg2), .imm (imm),
        .bj_inst_exe (bj_inst_exe), .alu_fn_exe (alu_fn_exe), .alu_opt_exe (alu_opt_exe),
        .data_sel_exe (data_sel_exe), .wb_sel_exe (wb_sel_exe),
        .read_width_exe (read_width_exe), .wrt_dst_exe (wrt_dst_exe),
        .mem_wrt_en_exe (mem_wrt_en_exe), .reg_wrt_en_exe (reg_wrt_en_exe),
        .read_unsigned_exe (read_unsigned_exe), .rd_en_exe (rd_en_exe),
        .fwd_a (fwd_a), .fwd_b (fwd_b), .wbdata_wb (wbdata_wb), .stall_mem (stall_mem),
        .next_pc_mem (next_pc_mem), .write_data_mem (write_data_mem),
        .alu_result_mem (alu_result_mem), .branch_pc (branch_pc), .branch (branch),
        .wb_sel_mem (wb_sel_mem), .read_width_mem (read_width_mem),
        .wrt_dst_mem (wrt_dst_mem), .mem_wrt_en_mem (mem_wrt_en_mem),
        .reg_wrt_en_mem (reg_wrt_en_mem), .read_unsigned_mem (read_unsigned_mem),
        .rd_en_mem (rd_en_mem)
    );

endmodule

// File: dv/tb_exe_top.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module tb_exe_top
    import exe_pkg::*;
();

    localparam int N_TABLE = 28;
    localparam int N_RAND  = 200;
    localparam int LIMIT   = 16 + 2 * (N_TABLE + N_RAND) + 100;

    typedef struct {
        logic [`XLEN-1:0]   r1, r2, imm;
        logic [`REG_AW-1:0] rs1, rs2, dst, wbd;
        bj_e                bj;
        alu_fn_e            fn;
        logic               we, wbwe, opt, dsel, stall, br;
        logic [`XLEN-1:0]   bpc, alu, wd;
    } row_t;

    logic               clk, rst_n, stall_mem, alu_opt_exe, data_sel_exe;
    logic [`XLEN-1:0]   next_pc_exe, reg1, reg2, imm, wbdata_wb;
    logic [`REG_AW-1:0] rs1_exe, rs2_exe, wrt_dst_exe, wrt_dst_wb;
    logic               mem_wrt_en_exe, reg_wrt_en_exe, read_unsigned_exe, rd_en_exe;
    logic               reg_wrt_en_wb;
    bj_e                bj_inst_exe;
    alu_fn_e            alu_fn_exe;
    wb_sel_e            wb_sel_exe, wb_sel_mem;
    mem_width_e         read_width_exe, read_width_mem;
    logic [`XLEN-1:0]   next_pc_mem, write_data_mem, alu_result_mem, branch_pc;
    logic               branch, mem_wrt_en_mem, reg_wrt_en_mem, read_unsigned_mem, rd_en_mem;
    logic [`REG_AW-1:0] wrt_dst_mem;

    row_t               tbl[$];
    logic [`XLEN-1:0]   h_pc;       // what the ex/mem register should hold
    logic [`REG_AW-1:0] h_dst;
    logic               h_we;
    int                 h_i;

    exe_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= LIMIT) begin
                $display("timeout: no end of test after %0d cycles", LIMIT);
                $display("Done: errors found");
                $fatal(1, "simulation stopped by timeout");
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [`XLEN-1:0] act, exp);
        $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        $display("Done: errors found");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] act, exp);
        if (act !== exp) report_mismatch(name, act, exp);
    endtask

    task automatic check_bit(input string name, input logic act, exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_reg_addr(input string name, input logic [`REG_AW-1:0] act, exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_wb_sel(input string name, input wb_sel_e act, exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic check_width(input string name, input mem_width_e act, exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected alu result straight from the rv32i rules
    function automatic logic [`XLEN-1:0] alu_model(input logic [`XLEN-1:0] a, b,
                                                    input alu_fn_e fn, input logic opt);
        logic [4:0] sh;
        sh = b[4:0];
        case (fn)
            ALU_ADD:  return opt ? a - b : a + b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SR: begin
                if (opt) return $unsigned($signed(a) >>> sh);
                return a >> sh;
            end
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // fl is {we, wbwe, opt, dsel, stall, br}
    task automatic add(input logic [`XLEN-1:0] r1, r2, im, input int rs1, rs2, dst, wbd,
                       input bj_e bj, input alu_fn_e fn, input int fl,
                       input logic [`XLEN-1:0] bpc, alu, wd);
        row_t r;
        r.r1    = r1;
        r.r2    = r2;
        r.imm   = im;
        r.rs1   = 5'(rs1);
        r.rs2   = 5'(rs2);
        r.dst   = 5'(dst);
        r.wbd   = 5'(wbd);
        r.bj    = bj;
        r.fn    = fn;
        r.we    = fl[5];
        r.wbwe  = fl[4];
        r.opt   = fl[3];
        r.dsel  = fl[2];
        r.stall = fl[1];
        r.br    = fl[0];
        r.bpc   = bpc;
        r.alu   = alu;
        r.wd    = wd;
        tbl.push_back(r);
    endtask

    // pc of row i is 'h100 + 4*i, wbdata_wb is always 'hb0b
    task automatic fill_table();
        add(7, 5, 'h10, 0, 0, 1, 0, BJ_NONE, ALU_ADD, 'b100000, 'h110, 'hc, 5);
        add(7, 5, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_ADD, 'b001000, 'h114, 2, 5);
        add(1, 4, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_SLL, 'b000000, 'h118, 'h10, 4);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_SLT, 'b000000, 'h11c, 1, 1);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_SLTU, 'b000000, 'h120, 0, 1);
        add('hf0f0, 'hff00, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_XOR, 'b000000, 'h124, 'hff0, 'hff00);
        add('h80000000, 4, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_SR, 'b000000, 'h128, 'h8000000, 4);
        add('h80000000, 4, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_SR, 'b001000, 'h12c, 'hf8000000, 4);
        add('hf0f0, 'hff00, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_OR, 'b000000, 'h130, 'hfff0, 'hff00);
        add('hf0f0, 'hff00, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_AND, 'b000000, 'h134, 'hf000, 'hff00);
        add('h100, 5, 'h20, 0, 0, 3, 0, BJ_NONE, ALU_ADD, 'b100100, 'h148, 'h120, 5);
        add(3, 0, 'h21, 0, 0, 0, 0, BJ_NONE, ALU_SLL, 'b000100, 'h14d, 6, 0);
        add(5, 5, 'h10, 0, 0, 0, 0, BJ_BEQ, ALU_ADD, 'b000001, 'h140, 'ha, 5);
        add(5, 5, 'h10, 0, 0, 0, 0, BJ_BNE, ALU_ADD, 'b000000, 'h144, 'ha, 5);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_BLT, ALU_ADD, 'b000001, 'h148, 0, 1);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_BGE, ALU_ADD, 'b000000, 'h14c, 0, 1);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_BLTU, ALU_ADD, 'b000000, 'h150, 0, 1);
        add('hffffffff, 1, 'h10, 0, 0, 0, 0, BJ_BGEU, ALU_ADD, 'b000001, 'h154, 0, 1);
        add(0, 0, 'h10, 0, 0, 0, 0, BJ_JAL, ALU_ADD, 'b000001, 'h158, 0, 0);
        add('h2000, 0, 'h10, 0, 0, 5, 0, BJ_JALR, ALU_ADD, 'b100001, 'h2010, 'h2000, 0);
        add(1, 3, 'h10, 5, 0, 6, 5, BJ_NONE, ALU_ADD, 'b110000, 'h160, 'h2003, 3);
        add(1, 9, 'h10, 7, 7, 8, 7, BJ_NONE, ALU_ADD, 'b010000, 'h164, 'h1616, 'hb0b);
        add(1, 2, 'h10, 8, 0, 0, 8, BJ_NONE, ALU_ADD, 'b100000, 'h168, 3, 2);
        add(4, 4, 'h10, 0, 0, 9, 0, BJ_NONE, ALU_ADD, 'b110000, 'h16c, 8, 4);
        add(1, 1, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_ADD, 'b000010, 'h170, 8, 4);
        add(2, 2, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_ADD, 'b000010, 'h174, 8, 4);
        add(0, 3, 'h10, 9, 9, 0, 0, BJ_NONE, ALU_ADD, 'b000000, 'h178, 'h10, 8);
        add(0, 0, 'h10, 0, 0, 0, 0, BJ_NONE, ALU_ADD, 'b000000, 'h17c, 0, 0);
    endtask

    task automatic run_row(input row_t r, input int i);
        next_pc_exe       = 32'h100 + 32'(4 * i);
        reg1              = r.r1;
        reg2              = r.r2;
        imm               = r.imm;
        rs1_exe           = r.rs1;
        rs2_exe           = r.rs2;
        bj_inst_exe       = r.bj;
        alu_fn_exe        = r.fn;
        alu_opt_exe       = r.opt;
        data_sel_exe      = r.dsel;
        wrt_dst_exe       = r.dst;
        reg_wrt_en_exe    = r.we;
        wrt_dst_wb        = r.wbd;
        reg_wrt_en_wb     = r.wbwe;
        wbdata_wb         = 32'hb0b;
        stall_mem         = r.stall;
        wb_sel_exe        = wb_sel_e'(2'(i % 3));      // control fields follow the row index
        read_width_exe    = mem_width_e'(2'((i + 1) % 3));
        mem_wrt_en_exe    = i[0];
        read_unsigned_exe = i[1];
        rd_en_exe         = i[2];
        if (!r.stall) begin
            h_pc  = next_pc_exe;
            h_dst = r.dst;
            h_we  = r.we;
            h_i   = i;
        end
        @(negedge clk);
        check_bit("branch", branch, r.br);
        check_word("branch_pc", branch_pc, r.bpc);
        @(posedge clk);
        #2;
        check_word("alu_result_mem", alu_result_mem, r.alu);
        check_word("write_data_mem", write_data_mem, r.wd);
        check_word("next_pc_mem", next_pc_mem, h_pc);
        check_reg_addr("wrt_dst_mem", wrt_dst_mem, h_dst);
        check_bit("reg_wrt_en_mem", reg_wrt_en_mem, h_we);
        check_wb_sel("wb_sel_mem", wb_sel_mem, wb_sel_e'(2'(h_i % 3)));
        check_width("read_width_mem", read_width_mem, mem_width_e'(2'((h_i + 1) % 3)));
        check_bit("mem_wrt_en_mem", mem_wrt_en_mem, h_i[0]);
        check_bit("read_unsigned_mem", read_unsigned_mem, h_i[1]);
        check_bit("rd_en_mem", rd_en_mem, h_i[2]);
    endtask

    initial begin
        row_t        r;
        logic [31:0] x;
        rst_n             = 1'b0;
        stall_mem         = 1'b0;
        next_pc_exe       = '0;
        reg1              = '0;
        reg2              = '0;
        imm               = '0;
        rs1_exe           = '0;
        rs2_exe           = '0;
        bj_inst_exe       = BJ_NONE;
        alu_fn_exe        = ALU_ADD;
        alu_opt_exe       = 1'b0;
        data_sel_exe      = 1'b0;
        wb_sel_exe        = WB_ALU;
        read_width_exe    = MW_BYTE;
        wrt_dst_exe       = '0;
        mem_wrt_en_exe    = 1'b0;
        reg_wrt_en_exe    = 1'b0;
        read_unsigned_exe = 1'b0;
        rd_en_exe         = 1'b0;
        wrt_dst_wb        = '0;
        reg_wrt_en_wb     = 1'b0;
        wbdata_wb         = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_word("next_pc_mem", next_pc_mem, 32'h0);
        check_word("write_data_mem", write_data_mem, 32'h0);
        check_word("alu_result_mem", alu_result_mem, 32'h0);
        check_reg_addr("wrt_dst_mem", wrt_dst_mem, 5'd0);
        check_bit("mem_wrt_en_mem", mem_wrt_en_mem, 1'b0);
        check_bit("reg_wrt_en_mem", reg_wrt_en_mem, 1'b0);
        check_bit("read_unsigned_mem", read_unsigned_mem, 1'b0);
        check_bit("rd_en_mem", rd_en_mem, 1'b0);
        check_wb_sel("wb_sel_mem", wb_sel_mem, WB_ALU);
        check_width("read_width_mem", read_width_mem, MW_BYTE);
        fill_table();
        for (int i = 0; i < tbl.size(); i++) begin
            run_row(tbl[i], i);
        end
        x = 32'd64;
        for (int k = 0; k < N_RAND; k++) begin
            x       = xorshift(x);
            r.r1    = x;
            x       = xorshift(x);
            r.r2    = x;
            x       = xorshift(x);
            r.imm   = x;
            r.fn    = alu_fn_e'(x[2:0]);
            r.opt   = x[3];
            r.dsel  = x[4];
            r.we    = x[5];
            r.rs1   = '0;                              // no forwarding on random rows
            r.rs2   = '0;
            r.dst   = x[10:6];
            r.wbd   = '0;
            r.wbwe  = 1'b0;
            r.stall = 1'b0;
            r.bj    = BJ_NONE;
            r.br    = 1'b0;
            r.bpc   = 32'h100 + 32'(4 * (N_TABLE + k)) + r.imm;
            r.alu   = alu_model(r.r1, r.dsel ? r.imm : r.r2, r.fn, r.opt);
            r.wd    = r.r2;
            run_row(r, N_TABLE + k);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/exe_pkg.sv
rtl/alu.sv
rtl/branch_ctrl.sv
rtl/forwarding_unit.sv
rtl/execute.sv
rtl/exe_top.sv
dv/tb_exe_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tb_exe_top -o sim_exe
./obj_dir/sim_exe
